// ==== common/uart_defs.svh ====
// channel count and bus widths of the multi-channel UART, included by the RTL and the testbench
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// lanes in each direction
`define UART_CHANNELS 4

// data bits per frame
`define UART_DATA_W 8

// baud divider width, one bit lasts clk_divider_i cycles
`define UART_DIV_W 16

// channel tag width, log2 of the channel count
`define UART_CHAN_W 2

`endif

// ==== common/uart_pkg.sv ====
// shared state and parity types plus the parity helper for the UART lanes and their testbench
`default_nettype none

`include "uart_defs.svh"

package uart_pkg;

    typedef enum logic [1:0] {
        PAR_NONE = 2'd0,
        PAR_EVEN = 2'd1,
        PAR_ODD  = 2'd2
    } parity_e;

    typedef enum logic [2:0] {
        IDLE,
        START,
        DATA,
        PARITY,
        STOP,
        WAIT
    } tx_state_e;

    typedef enum logic [2:0] {
        R_IDLE,
        R_START,
        R_DATA,
        R_PARITY,
        R_STOP
    } rx_state_e;

    // even: data plus bit has an even count of ones, odd: an odd count
    function automatic logic parity_bit(input logic [`UART_DATA_W-1:0] data,
                                        input parity_e mode);
        logic ones;
        ones = ^data;
        case (mode)
            PAR_EVEN: return ones;
            PAR_ODD:  return ~ones;
            default:  return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== uart/uart_tx.sv ====
// one UART transmit lane, takes a byte over valid/ready and sends start, data, parity, stop
`default_nettype none

`include "uart_defs.svh"

module uart_tx (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [`UART_DIV_W-1:0]  clk_divider_i,
    input  uart_pkg::parity_e       parity_i,
    input  logic [`UART_DATA_W-1:0] tdata_i,
    input  logic                    tvalid_i,
    output logic                    tready_o,
    output logic                    uart_tx_o
);

    localparam int CNT_W = $clog2(`UART_DATA_W);

    uart_pkg::tx_state_e     state;
    logic [`UART_DIV_W-1:0]  baud_cnt;
    logic [CNT_W-1:0]        bit_cnt;
    logic [`UART_DATA_W-1:0] tx_shift;
    logic                    par_bit;
    logic                    par_en;
    logic                    accept;
    logic                    baud_done;
    logic                    bit_done;

    assign tready_o  = (state == uart_pkg::IDLE);
    assign accept    = tvalid_i & tready_o;
    assign baud_done = (baud_cnt == clk_divider_i - 1'b1);
    assign bit_done  = (bit_cnt == CNT_W'(`UART_DATA_W - 1));

    // line is registered, each bit is set up on the edge that ends the previous one
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state     <= uart_pkg::IDLE;
            uart_tx_o <= 1'b1;
            bit_cnt   <= '0;
        end else begin
            case (state)
                uart_pkg::IDLE: begin
                    uart_tx_o <= 1'b1;
                    if (accept) begin
                        state     <= uart_pkg::START;
                        uart_tx_o <= 1'b0;
                    end
                end
                uart_pkg::START: begin
                    if (baud_done) begin
                        state     <= uart_pkg::DATA;
                        uart_tx_o <= tx_shift[0];
                        bit_cnt   <= '0;
                    end
                end
                uart_pkg::DATA: begin
                    if (baud_done) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_done) begin
                            if (par_en) begin
                                state     <= uart_pkg::PARITY;
                                uart_tx_o <= par_bit;
                            end else begin
                                state     <= uart_pkg::STOP;
                                uart_tx_o <= 1'b1;
                            end
                        end else begin
                            // shift register moves on this same edge
                            uart_tx_o <= tx_shift[1];
                        end
                    end
                end
                uart_pkg::PARITY: begin
                    if (baud_done) begin
                        state     <= uart_pkg::STOP;
                        uart_tx_o <= 1'b1;
                    end
                end
                uart_pkg::STOP: begin
                    if (baud_done) begin
                        state <= uart_pkg::WAIT;
                    end
                end
                uart_pkg::WAIT: begin
                    state <= uart_pkg::IDLE;
                end
                default: begin
                    state     <= uart_pkg::IDLE;
                    uart_tx_o <= 1'b1;
                end
            endcase
        end
    end

    // counter restarts at every bit boundary and rests while idle
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            baud_cnt <= '0;
        end else if (state == uart_pkg::IDLE || baud_done) begin
            baud_cnt <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    // frame payload, parity is fixed at acceptance
    always_ff @(posedge clk_i) begin
        if (accept) begin
            tx_shift <= tdata_i;
            par_bit  <= uart_pkg::parity_bit(tdata_i, parity_i);
            par_en   <= (parity_i != uart_pkg::PAR_NONE);
        end else if (baud_done && state == uart_pkg::DATA) begin
            tx_shift <= tx_shift >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== uart/uart_rx.sv ====
// one UART receive lane, samples mid-bit, checks parity and stop, holds the byte until taken
`default_nettype none

`include "uart_defs.svh"

module uart_rx (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic [`UART_DIV_W-1:0]  clk_divider_i,
    input  uart_pkg::parity_e       parity_i,
    input  logic                    uart_rx_i,
    output logic [`UART_DATA_W-1:0] rdata_o,
    output logic                    rerr_o,
    output logic                    rvalid_o,
    input  logic                    take_i
);

    localparam int CNT_W = $clog2(`UART_DATA_W);

    uart_pkg::rx_state_e     state;
    logic                    rx_meta;
    logic                    rx_sync;
    logic [`UART_DIV_W-1:0]  baud_cnt;
    logic [CNT_W-1:0]        bit_cnt;
    logic [`UART_DATA_W-1:0] rx_shift;
    logic                    par_err;
    logic                    baud_done;
    logic                    half_done;
    logic                    bit_done;
    logic                    frame_done;

    assign baud_done  = (baud_cnt == clk_divider_i - 1'b1);
    assign half_done  = (baud_cnt == (clk_divider_i >> 1) - 1'b1);
    assign bit_done   = (bit_cnt == CNT_W'(`UART_DATA_W - 1));
    assign frame_done = (state == uart_pkg::R_STOP) && baud_done;

    // line is asynchronous to clk_i
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= uart_rx_i;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state    <= uart_pkg::R_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
            case (state)
                uart_pkg::R_IDLE: begin
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                    if (!rx_sync) begin
                        state <= uart_pkg::R_START;
                    end
                end
                uart_pkg::R_START: begin
                    // a high level at mid start bit was only a glitch
                    if (half_done) begin
                        baud_cnt <= '0;
                        state    <= rx_sync ? uart_pkg::R_IDLE : uart_pkg::R_DATA;
                    end
                end
                uart_pkg::R_DATA: begin
                    if (baud_done) begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_done) begin
                            if (parity_i != uart_pkg::PAR_NONE) begin
                                state <= uart_pkg::R_PARITY;
                            end else begin
                                state <= uart_pkg::R_STOP;
                            end
                        end
                    end
                end
                uart_pkg::R_PARITY: begin
                    if (baud_done) begin
                        baud_cnt <= '0;
                        state    <= uart_pkg::R_STOP;
                    end
                end
                uart_pkg::R_STOP: begin
                    if (baud_done) begin
                        baud_cnt <= '0;
                        state    <= uart_pkg::R_IDLE;
                    end
                end
                default: state <= uart_pkg::R_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == uart_pkg::R_START && half_done) begin
            par_err <= 1'b0;
        end
        if (state == uart_pkg::R_DATA && baud_done) begin
            rx_shift <= {rx_sync, rx_shift[`UART_DATA_W-1:1]};
        end
        if (state == uart_pkg::R_PARITY && baud_done) begin
            par_err <= (rx_sync != uart_pkg::parity_bit(rx_shift, parity_i));
        end
        // an untaken byte gets overwritten and flagged as overrun
        if (frame_done) begin
            rdata_o <= rx_shift;
            rerr_o  <= par_err | ~rx_sync | (rvalid_o & ~take_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rvalid_o <= 1'b0;
        end else if (frame_done) begin
            rvalid_o <= 1'b1;
        end else if (take_i) begin
            rvalid_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/tx_dispatch.sv ====
// decodes the channel tag of the input byte stream into per-lane valids and returns that lane's ready
`default_nettype none

`include "uart_defs.svh"

module tx_dispatch (
    input  logic [`UART_DATA_W-1:0]   s_tdata_i,
    input  logic [`UART_CHAN_W-1:0]   s_tchan_i,
    input  logic                      s_tvalid_i,
    output logic                      s_tready_o,
    output logic [`UART_CHANNELS-1:0] lane_valid_o,
    output logic [`UART_DATA_W-1:0]   lane_data_o,
    input  logic [`UART_CHANNELS-1:0] lane_ready_i
);

    // one-hot valid, only the tagged lane sees the byte
    always_comb begin
        lane_valid_o            = '0;
        lane_valid_o[s_tchan_i] = s_tvalid_i;
    end

    // handshake completes on the addressed lane alone
    assign s_tready_o = lane_ready_i[s_tchan_i];

    // data bus is shared, the lane valid qualifies it
    assign lane_data_o = s_tdata_i;

endmodule

`default_nettype wire

// ==== verilog/rx_collect.sv ====
// round-robin merge of the receive lanes into one registered, tagged output stream
`default_nettype none

`include "uart_defs.svh"

module rx_collect (
    input  logic                                         clk_i,
    input  logic                                         rstn_i,
    input  logic [`UART_CHANNELS-1:0][`UART_DATA_W-1:0]  lane_data_i,
    input  logic [`UART_CHANNELS-1:0]                    lane_err_i,
    input  logic [`UART_CHANNELS-1:0]                    lane_valid_i,
    output logic [`UART_CHANNELS-1:0]                    lane_take_o,
    output logic [`UART_DATA_W-1:0]                      m_tdata_o,
    output logic [`UART_CHAN_W-1:0]                      m_tchan_o,
    output logic                                         m_terr_o,
    output logic                                         m_tvalid_o,
    input  logic                                         m_tready_i
);

    localparam int CW = `UART_CHAN_W;

    logic [CW-1:0] last_q;
    logic [CW-1:0] scan_idx;
    logic [CW-1:0] grant_idx;
    logic          grant_found;
    logic          load;

    // scan begins one past the last grant, so a busy lane cannot starve the rest
    always_comb begin
        grant_found = 1'b0;
        grant_idx   = last_q;
        scan_idx    = last_q;
        for (int i = 1; i <= `UART_CHANNELS; i++) begin
            scan_idx = last_q + CW'(i);
            if (!grant_found && lane_valid_i[scan_idx]) begin
                grant_found = 1'b1;
                grant_idx   = scan_idx;
            end
        end
    end

    // register refills on the cycle its word leaves
    assign load        = grant_found & (~m_tvalid_o | m_tready_i);
    assign lane_take_o = {`UART_CHANNELS{load}} & (`UART_CHANNELS'(1) << grant_idx);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            m_tvalid_o <= 1'b0;
            m_terr_o   <= 1'b0;
            last_q     <= '1;
        end else if (load) begin
            m_tvalid_o <= 1'b1;
            m_terr_o   <= lane_err_i[grant_idx];
            last_q     <= grant_idx;
        end else if (m_tready_i) begin
            m_tvalid_o <= 1'b0;
            m_terr_o   <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            m_tdata_o <= lane_data_i[grant_idx];
            m_tchan_o <= grant_idx;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uart_multi_top.sv ====
// multi-channel UART top, dispatcher and transmit lanes on one side, receive lanes and collector on the other
`default_nettype none

`include "uart_defs.svh"

module uart_multi_top (
    input  logic                      clk_i,
    input  logic                      rstn_i,
    input  logic [`UART_DIV_W-1:0]    clk_divider_i,
    input  uart_pkg::parity_e         parity_i,
    input  logic [`UART_DATA_W-1:0]   s_tdata_i,
    input  logic [`UART_CHAN_W-1:0]   s_tchan_i,
    input  logic                      s_tvalid_i,
    output logic                      s_tready_o,
    output logic [`UART_DATA_W-1:0]   m_tdata_o,
    output logic [`UART_CHAN_W-1:0]   m_tchan_o,
    output logic                      m_terr_o,
    output logic                      m_tvalid_o,
    input  logic                      m_tready_i,
    output logic [`UART_CHANNELS-1:0] uart_tx_o,
    input  logic [`UART_CHANNELS-1:0] uart_rx_i
);

    logic [`UART_CHANNELS-1:0]                   tx_valid;
    logic [`UART_CHANNELS-1:0]                   tx_ready;
    logic [`UART_DATA_W-1:0]                     tx_data;
    logic [`UART_CHANNELS-1:0][`UART_DATA_W-1:0] rx_data;
    logic [`UART_CHANNELS-1:0]                   rx_err;
    logic [`UART_CHANNELS-1:0]                   rx_valid;
    logic [`UART_CHANNELS-1:0]                   rx_take;

    tx_dispatch u_dispatch (
        .s_tdata_i    (s_tdata_i),
        .s_tchan_i    (s_tchan_i),
        .s_tvalid_i   (s_tvalid_i),
        .s_tready_o   (s_tready_o),
        .lane_valid_o (tx_valid),
        .lane_data_o  (tx_data),
        .lane_ready_i (tx_ready)
    );

    for (genvar ch = 0; ch < `UART_CHANNELS; ch++) begin : g_tx
        uart_tx u_tx (
            .clk_i         (clk_i),
            .rstn_i        (rstn_i),
            .clk_divider_i (clk_divider_i),
            .parity_i      (parity_i),
            .tdata_i       (tx_data),
            .tvalid_i      (tx_valid[ch]),
            .tready_o      (tx_ready[ch]),
            .uart_tx_o     (uart_tx_o[ch])
        );
    end

    for (genvar ch = 0; ch < `UART_CHANNELS; ch++) begin : g_rx
        uart_rx u_rx (
            .clk_i         (clk_i),
            .rstn_i        (rstn_i),
            .clk_divider_i (clk_divider_i),
            .parity_i      (parity_i),
            .uart_rx_i     (uart_rx_i[ch]),
            .rdata_o       (rx_data[ch]),
            .rerr_o        (rx_err[ch]),
            .rvalid_o      (rx_valid[ch]),
            .take_i        (rx_take[ch])
        );
    end

    rx_collect u_collect (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .lane_data_i  (rx_data),
        .lane_err_i   (rx_err),
        .lane_valid_i (rx_valid),
        .lane_take_o  (rx_take),
        .m_tdata_o    (m_tdata_o),
        .m_tchan_o    (m_tchan_o),
        .m_terr_o     (m_terr_o),
        .m_tvalid_o   (m_tvalid_o),
        .m_tready_i   (m_tready_i)
    );

endmodule

`default_nettype wire

// ==== sim/uart_multi_assertions.sv ====
// concurrent checks on the multi-channel UART top, attached to every instance of it by bind
`default_nettype none

`include "uart_defs.svh"

module uart_multi_assertions (
    input wire logic                      clk_i,
    input wire logic                      rstn_i,
    input wire logic [`UART_CHANNELS-1:0] uart_tx_o,
    input wire logic [`UART_DATA_W-1:0]   m_tdata_o,
    input wire logic [`UART_CHAN_W-1:0]   m_tchan_o,
    input wire logic                      m_terr_o,
    input wire logic                      m_tvalid_o,
    input wire logic                      m_tready_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // every line idles high once reset is released
    a_lines_idle: assert property (@(posedge clk_i) $rose(rstn_i) |-> (&uart_tx_o))
        else $error("serial lines not idle after reset");

    // a stalled output word must not change
    a_word_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (m_tvalid_o && !m_tready_i) |=>
        (m_tvalid_o && $stable({m_tdata_o, m_tchan_o, m_terr_o})))
        else $error("output word changed while stalled");

    a_err_valid: assert property (@(posedge clk_i) disable iff (!rstn_i)
        m_terr_o |-> m_tvalid_o)
        else $error("error flag set without valid");

endmodule

bind uart_multi_top uart_multi_assertions u_assertions (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .uart_tx_o  (uart_tx_o),
    .m_tdata_o  (m_tdata_o),
    .m_tchan_o  (m_tchan_o),
    .m_terr_o   (m_terr_o),
    .m_tvalid_o (m_tvalid_o),
    .m_tready_i (m_tready_i)
);

`default_nettype wire

// ==== sim/uart_multi_tb.sv ====
// loopback testbench for the multi-channel UART that runs a stimulus table and checks the output stream
`default_nettype none

`include "uart_defs.svh"

module uart_multi_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int D     = 8;
    localparam int NROWS = 16;
    localparam int CH    = `UART_CHANNELS;
    // twelve bit times per row plus some slack
    localparam int LIMIT = NROWS * 12 * D + 200;

    typedef struct packed {
        logic [`UART_CHAN_W-1:0] chan;
        logic [7:0]              data;
        logic                    rnd;
        uart_pkg::parity_e       par;
        logic [1:0]              inj;
        logic                    exp_err;
        logic                    lost;
        logic                    stall;
        logic                    last;
    } row_t;

    logic                    clk_i = 1'b0;
    logic                    rstn_i;
    logic [`UART_DIV_W-1:0]  clk_divider_i;
    uart_pkg::parity_e       parity_i;
    logic [`UART_DATA_W-1:0] s_tdata_i;
    logic [`UART_CHAN_W-1:0] s_tchan_i;
    logic                    s_tvalid_i;
    logic                    s_tready_o;
    logic [`UART_DATA_W-1:0] m_tdata_o;
    logic [`UART_CHAN_W-1:0] m_tchan_o;
    logic                    m_terr_o;
    logic                    m_tvalid_o;
    logic                    m_tready_i;
    logic [CH-1:0]           uart_tx_o;
    logic [CH-1:0]           uart_rx_i;
    logic [CH-1:0]           force_en;
    logic [CH-1:0]           force_val;

    row_t        rows [NROWS];
    logic [8:0]  exp_q [CH][$];
    logic [31:0] rng;
    int          mismatch_cnt;
    int          other_cnt;

    // loopback with a per-line override for bit-banged frames
    assign uart_rx_i = (uart_tx_o & ~force_en) | (force_val & force_en);

    always #50 clk_i = ~clk_i;

    uart_multi_top dut_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .clk_divider_i (clk_divider_i),
        .parity_i      (parity_i),
        .s_tdata_i     (s_tdata_i),
        .s_tchan_i     (s_tchan_i),
        .s_tvalid_i    (s_tvalid_i),
        .s_tready_o    (s_tready_o),
        .m_tdata_o     (m_tdata_o),
        .m_tchan_o     (m_tchan_o),
        .m_terr_o      (m_terr_o),
        .m_tvalid_o    (m_tvalid_o),
        .m_tready_i    (m_tready_i),
        .uart_tx_o     (uart_tx_o),
        .uart_rx_i     (uart_rx_i)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // even mode makes the total count of ones even and odd mode makes it odd
    function automatic logic expected_parity(input logic [7:0] data, input uart_pkg::parity_e mode);
        int ones;
        ones = 0;
        for (int i = 0; i < 8; i++) begin
            ones += int'(data[i]);
        end
        if (mode == uart_pkg::PAR_ODD) begin
            return (ones % 2) == 0;
        end
        return (ones % 2) == 1;
    endfunction

    task automatic add_row(input int idx, input int chan, input logic [7:0] data, input logic rnd,
                           input uart_pkg::parity_e par, input logic [1:0] inj,
                           input logic exp_err, input logic lost, input logic stall,
                           input logic last);
        rows[idx] = '{`UART_CHAN_W'(chan), data, rnd, par, inj, exp_err, lost, stall, last};
    endtask

    task automatic send_byte(input logic [`UART_CHAN_W-1:0] chan, input logic [7:0] data);
        @(posedge clk_i);
        s_tdata_i  <= data;
        s_tchan_i  <= chan;
        s_tvalid_i <= 1'b1;
        forever begin
            @(posedge clk_i);
            if (s_tready_o) begin
                break;
            end
        end
        s_tvalid_i <= 1'b0;
    endtask

    task automatic drive_bit(input logic [`UART_CHAN_W-1:0] chan, input logic b);
        force_val[chan] <= b;
        repeat (D) @(posedge clk_i);
    endtask

    // inj 1 flips the parity bit and inj 2 sends a low stop bit
    task automatic bang_frame(input logic [`UART_CHAN_W-1:0] chan, input logic [7:0] data,
                              input uart_pkg::parity_e par, input logic [1:0] inj);
        @(posedge clk_i);
        force_en[chan] <= 1'b1;
        drive_bit(chan, 1'b0);
        for (int i = 0; i < 8; i++) begin
            drive_bit(chan, data[i]);
        end
        if (par != uart_pkg::PAR_NONE) begin
            drive_bit(chan, expected_parity(data, par) ^ (inj == 2'd1));
        end
        drive_bit(chan, inj != 2'd2);
        drive_bit(chan, 1'b1);
        force_en[chan] <= 1'b0;
    endtask

    task automatic wait_drain(input logic [`UART_CHAN_W-1:0] chan, input logic iso);
        int pending;
        forever begin
            @(posedge clk_i);
            if (iso && ((uart_tx_o | (CH'(1) << chan)) != {CH{1'b1}})) begin
                $display("line of another channel toggled while channel %0d sent", chan);
                other_cnt++;
            end
            pending = 0;
            for (int k = 0; k < CH; k++) begin
                pending += exp_q[k].size();
            end
            if (pending == 0) begin
                break;
            end
        end
    endtask

    // words are sampled mid-cycle and transfer on the next rising edge
    always @(negedge clk_i) begin
        logic [8:0] exp;
        if (rstn_i && m_tvalid_o && m_tready_i) begin
            if (exp_q[m_tchan_o].size() == 0) begin
                $display("unexpected word %h on channel %0d at %0t", m_tdata_o, m_tchan_o, $time);
                other_cnt++;
            end else begin
                exp = exp_q[m_tchan_o].pop_front();
                if (m_tdata_o != exp[7:0]) begin
                    $display("mismatch at %0t: m_tdata_o got %h expected %h",
                             $time, m_tdata_o, exp[7:0]);
                    mismatch_cnt++;
                end
                if (m_terr_o != exp[8]) begin
                    $display("mismatch at %0t: m_terr_o got %b expected %b",
                             $time, m_terr_o, exp[8]);
                    mismatch_cnt++;
                end
            end
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk_i);
        $display("timeout: the output stream did not drain within %0d cycles", LIMIT);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        row_t       row;
        logic [7:0] data;
        logic       stalled;
        rstn_i        = 1'b0;
        clk_divider_i = `UART_DIV_W'(D);
        parity_i      = uart_pkg::PAR_NONE;
        s_tdata_i     = '0;
        s_tchan_i     = '0;
        s_tvalid_i    = 1'b0;
        m_tready_i    = 1'b1;
        force_en      = '0;
        force_val     = '1;
        rng           = 32'd39;
        mismatch_cnt  = 0;
        other_cnt     = 0;
        stalled       = 1'b0;

        add_row(0, 0, 8'hA5, 0, uart_pkg::PAR_NONE, 0, 0, 0, 0, 1);
        add_row(1, 1, 8'h00, 1, uart_pkg::PAR_EVEN, 0, 0, 0, 0, 1);
        add_row(2, 2, 8'h00, 1, uart_pkg::PAR_ODD, 0, 0, 0, 0, 1);
        add_row(3, 3, 8'h00, 0, uart_pkg::PAR_ODD, 0, 0, 0, 0, 1);
        add_row(4, 0, 8'h00, 1, uart_pkg::PAR_EVEN, 0, 0, 0, 1, 0);
        add_row(5, 1, 8'h00, 1, uart_pkg::PAR_EVEN, 0, 0, 0, 1, 0);
        add_row(6, 2, 8'h00, 1, uart_pkg::PAR_EVEN, 0, 0, 0, 1, 0);
        add_row(7, 3, 8'h00, 1, uart_pkg::PAR_EVEN, 0, 0, 0, 1, 1);
        // the middle byte of three is overwritten in the lane
        add_row(8, 1, 8'h3C, 0, uart_pkg::PAR_NONE, 0, 0, 0, 1, 0);
        add_row(9, 1, 8'hC3, 0, uart_pkg::PAR_NONE, 0, 0, 1, 1, 0);
        add_row(10, 1, 8'h5A, 0, uart_pkg::PAR_NONE, 0, 1, 0, 1, 1);
        add_row(11, 2, 8'h96, 0, uart_pkg::PAR_EVEN, 1, 1, 0, 0, 1);
        add_row(12, 2, 8'h00, 1, uart_pkg::PAR_EVEN, 0, 0, 0, 0, 1);
        add_row(13, 3, 8'h71, 0, uart_pkg::PAR_NONE, 2, 1, 0, 0, 1);
        add_row(14, 3, 8'h00, 1, uart_pkg::PAR_NONE, 0, 0, 0, 0, 1);
        add_row(15, 0, 8'hFF, 0, uart_pkg::PAR_ODD, 0, 0, 0, 0, 1);

        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        if (!s_tready_o || m_tvalid_o || (uart_tx_o != {CH{1'b1}})) begin
            $display("reset state wrong: ready %b valid %b lines %b",
                     s_tready_o, m_tvalid_o, uart_tx_o);
            other_cnt++;
        end

        for (int r = 0; r < NROWS; r++) begin
            row = rows[r];
            data = row.data;
            if (row.rnd) begin
                rng  = xorshift32(rng);
                data = rng[7:0];
            end
            @(posedge clk_i);
            parity_i <= row.par;
            if (row.stall && !stalled) begin
                m_tready_i <= 1'b0;
                stalled = 1'b1;
            end
            if (!row.lost) begin
                exp_q[row.chan].push_back({row.exp_err, data});
            end
            if (row.inj == 2'd0) begin
                send_byte(row.chan, data);
            end else begin
                bang_frame(row.chan, data, row.par, row.inj);
            end
            if (row.last) begin
                if (stalled) begin
                    repeat (12 * D) @(posedge clk_i);
                    m_tready_i <= 1'b1;
                    stalled = 1'b0;
                end
                wait_drain(row.chan, !row.stall && row.inj == 2'd0);
            end
        end

        repeat (4 * D) @(posedge clk_i);
        $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+common
common/uart_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
verilog/tx_dispatch.sv
verilog/rx_collect.sv
verilog/uart_multi_top.sv
sim/uart_multi_assertions.sv
sim/uart_multi_tb.sv

// ==== Makefile ====
TOP = uart_multi_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -o sim_$(TOP)

run: build
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
